// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = core_tb
FILELIST  = project.f
BUILD     = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf $(BUILD)

// File: project.f
+incdir+source
source/core_pkg.sv
source/mem_if.sv
source/core_fetch.sv
source/core_exec.sv
source/core_regfile.sv
source/core_lsu.sv
source/mem_arbiter.sv
source/rv32e_core.sv
verification/core_tb.sv

// File: source/core_exec.sv
`timescale 1ns/10ps
`include "core_params.svh"

module core_exec (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic [`XLEN-1:0]           pc,
	input  core_pkg::inst_word_t       inst,
	input  logic                       exec_start,
	input  logic [`XLEN-1:0]           rs1_data,
	input  logic [`XLEN-1:0]           rs2_data,
	input  logic                       lsu_done,
	input  logic [`XLEN-1:0]           load_data,
	output logic [$clog2(`NREGS)-1:0]  rs1_addr,
	output logic [$clog2(`NREGS)-1:0]  rs2_addr,
	output logic [$clog2(`NREGS)-1:0]  rd_addr,
	output logic [`XLEN-1:0]           rd_wdata,
	output logic                       rd_wen,
	output logic [`XLEN-1:0]           next_pc,
	output logic                       mem_start,
	output logic [`XLEN-1:0]           mem_addr,
	output logic [`XLEN-1:0]           mem_wdata,
	output logic                       mem_write,
	output logic                       wb_valid
);
	import core_pkg::*;

	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	opcode_e          op;
	logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [`XLEN-1:0] alu_res;
	logic             is_mem;
	logic             taken;
	logic             mem_pending;

	assign op = opcode_e'(inst.r_fmt.opcode);

	// Register fields, upper bit dropped for RV32E
	assign rs1_addr = inst.r_fmt.rs1[$clog2(`NREGS)-1:0];
	assign rs2_addr = inst.r_fmt.rs2[$clog2(`NREGS)-1:0];
	assign rd_addr  = inst.r_fmt.rd[$clog2(`NREGS)-1:0];

	// ------------------------------------------------------------------------
	// Immediates
	// ------------------------------------------------------------------------
	assign imm_i = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
	assign imm_s = {{20{inst.r_fmt.funct7[6]}}, inst.r_fmt.funct7, inst.r_fmt.rd};
	assign imm_b = {{20{inst.r_fmt.funct7[6]}}, inst.r_fmt.rd[0], inst.r_fmt.funct7[5:0],
		inst.r_fmt.rd[4:1], 1'b0};
	assign imm_u = {inst.r_fmt.funct7, inst.r_fmt.rs2, inst.r_fmt.rs1, inst.r_fmt.funct3, 12'b0};
	assign imm_j = {{12{inst.r_fmt.funct7[6]}}, inst.r_fmt.rs1, inst.r_fmt.funct3,
		inst.r_fmt.rs2[0], inst.r_fmt.funct7[5:0], inst.r_fmt.rs2[4:1], 1'b0};

	always_comb begin
		alu_res = '0;
		case (op)
			OP_REG:  alu_res = inst.r_fmt.funct7[5] ? rs1_data - rs2_data : rs1_data + rs2_data;
			OP_IMM:  alu_res = rs1_data + imm_i;
			OP_LUI:  alu_res = imm_u;
			OP_JAL:  alu_res = pc + 32'd4;  // Link
			default: alu_res = '0;
		endcase
	end

	always_comb begin
		case (inst.r_fmt.funct3)
			F3_BEQ:  taken = (rs1_data == rs2_data);
			F3_BNE:  taken = (rs1_data != rs2_data);
			default: taken = 1'b0;
		endcase
	end

	assign next_pc = (op == OP_JAL) ? pc + imm_j :
		(op == OP_BRANCH && taken) ? pc + imm_b : pc + 32'd4;

	assign rd_wen   = (op == OP_REG) || (op == OP_IMM) || (op == OP_LUI) || (op == OP_JAL) ||
		(op == OP_LOAD);
	assign rd_wdata = (op == OP_LOAD) ? load_data : alu_res;

	// ------------------------------------------------------------------------
	// Memory request and write-back
	// ------------------------------------------------------------------------
	assign is_mem    = (op == OP_LOAD) || (op == OP_STORE);
	assign mem_write = (op == OP_STORE);
	assign mem_addr  = rs1_data + (mem_write ? imm_s : imm_i);
	assign mem_wdata = rs2_data;
	assign mem_start = exec_start && is_mem;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			mem_pending <= 1'b0;
		else if (mem_start)
			mem_pending <= 1'b1;
		else if (lsu_done)
			mem_pending <= 1'b0;
	end

	assign wb_valid = (exec_start && !is_mem) || (mem_pending && lsu_done);
endmodule

// File: source/core_fetch.sv
`timescale 1ns/10ps
`include "core_params.svh"

module core_fetch (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 wb_valid,
	input  logic [`XLEN-1:0]     next_pc,
	mem_if.requester             bus,
	output logic [`XLEN-1:0]     pc,
	output core_pkg::inst_word_t inst,
	output logic                 exec_start
);
	typedef enum logic [1:0] {
		S_IDLE,
		S_ADDR,
		S_DATA
	} fetch_state_e;

	fetch_state_e state;
	logic         boot;     // Still waiting for the first fetch
	logic         r_fire;

	assign r_fire = bus.rvalid && bus.rready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			boot       <= 1'b1;
			pc         <= `RESET_PC;
			exec_start <= 1'b0;
		end else begin
			exec_start <= r_fire;
			if (wb_valid)
				pc <= next_pc;
			case (state)
				S_IDLE: begin
					if (boot || wb_valid) begin
						state <= S_ADDR;
						boot  <= 1'b0;
					end
				end
				S_ADDR:  if (bus.arready) state <= S_DATA;
				S_DATA:  if (r_fire) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (r_fire)
			inst <= bus.rdata;
	end

	assign bus.arvalid = (state == S_ADDR);
	assign bus.araddr  = pc;
	assign bus.rready  = (state == S_DATA);

	// Fetch never writes
	assign bus.awvalid = 1'b0;
	assign bus.awaddr  = '0;
	assign bus.wvalid  = 1'b0;
	assign bus.wdata   = '0;
	assign bus.wstrb   = '0;
	assign bus.bready  = 1'b0;

	ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
		bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr));
endmodule

// File: source/core_lsu.sv
`timescale 1ns/10ps
`include "core_params.svh"

module core_lsu (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             mem_start,
	input  logic [`XLEN-1:0] mem_addr,
	input  logic [`XLEN-1:0] mem_wdata,
	input  logic             mem_write,
	mem_if.requester         bus,
	output logic             lsu_done,
	output logic [`XLEN-1:0] load_data
);
	typedef enum logic [1:0] {
		L_IDLE,
		L_RADDR,
		L_RDATA,
		L_WRITE
	} lsu_state_e;

	lsu_state_e       state;
	logic             aw_pend;   // aw not yet accepted
	logic             w_pend;    // w not yet accepted
	logic [`XLEN-1:0] addr_q;
	logic [`XLEN-1:0] wdata_q;
	logic             r_fire;
	logic             b_fire;

	assign r_fire = bus.rvalid && bus.rready;
	assign b_fire = bus.bvalid && bus.bready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state   <= L_IDLE;
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
		end else begin
			case (state)
				L_IDLE: begin
					if (mem_start) begin
						state   <= mem_write ? L_WRITE : L_RADDR;
						aw_pend <= mem_write;
						w_pend  <= mem_write;
					end
				end
				L_RADDR: if (bus.arready) state <= L_RDATA;
				L_RDATA: if (r_fire) state <= L_IDLE;
				L_WRITE: begin
					if (bus.awready)
						aw_pend <= 1'b0;
					if (bus.wready)
						w_pend <= 1'b0;
					if (b_fire)
						state <= L_IDLE;
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (mem_start) begin
			addr_q  <= mem_addr;
			wdata_q <= mem_wdata;
		end
	end

	assign bus.arvalid = (state == L_RADDR);
	assign bus.araddr  = addr_q;
	assign bus.rready  = (state == L_RDATA);
	assign bus.awvalid = aw_pend;
	assign bus.awaddr  = addr_q;
	assign bus.wvalid  = w_pend;
	assign bus.wdata   = wdata_q;
	assign bus.wstrb   = '1;         // Word stores only
	assign bus.bready  = (state == L_WRITE);

	assign lsu_done  = r_fire || b_fire;
	assign load_data = bus.rdata;

	start_when_idle: assert property (@(posedge clock) disable iff (!rst_n)
		mem_start |-> state == L_IDLE);
endmodule

// File: source/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Data and address width
`define XLEN 32

// General registers of RV32E
`define NREGS 16

`endif

// File: source/core_pkg.sv
package core_pkg;

	// ------------------------------------------------------------------------
	// Instruction word, seen as R-type or as I-type
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;   // S, B, U and J immediates come from r_fmt
	} inst_word_t;

	typedef enum logic [6:0] {
		OP_REG    = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LUI    = 7'b0110111,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

endpackage

// File: source/core_regfile.sv
`timescale 1ns/10ps
`include "core_params.svh"

module core_regfile #(
	parameter int NREGS = `NREGS
) (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic [$clog2(NREGS)-1:0] raddr1,
	input  logic [$clog2(NREGS)-1:0] raddr2,
	input  logic [$clog2(NREGS)-1:0] waddr,
	input  logic [`XLEN-1:0]         wdata,
	input  logic                     wen,
	input  logic                     wb_valid,
	output logic [`XLEN-1:0]         rdata1,
	output logic [`XLEN-1:0]         rdata2
);
	logic [`XLEN-1:0] regs [NREGS];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (wen && wb_valid && waddr != '0)   // x0 stays zero
			regs[waddr] <= wdata;
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];
endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/10ps
`include "core_params.svh"

module mem_arbiter (
	mem_if.arbiter             fetch_bus,
	mem_if.arbiter             lsu_bus,
	input  logic               clock,
	input  logic               rst_n,
	input  logic               io_master_awready,
	input  logic               io_master_wready,
	input  logic               io_master_bvalid,
	input  logic [1:0]         io_master_bresp,
	input  logic               io_master_arready,
	input  logic               io_master_rvalid,
	input  logic [1:0]         io_master_rresp,
	input  logic [`XLEN-1:0]   io_master_rdata,
	output logic               io_master_awvalid,
	output logic [`XLEN-1:0]   io_master_awaddr,
	output logic               io_master_wvalid,
	output logic [`XLEN-1:0]   io_master_wdata,
	output logic [`XLEN/8-1:0] io_master_wstrb,
	output logic               io_master_bready,
	output logic               io_master_arvalid,
	output logic [`XLEN-1:0]   io_master_araddr,
	output logic               io_master_rready
);
	logic rd_busy;   // A read is outstanding
	logic rd_lsu;    // Outstanding read belongs to the LSU

	// ------------------------------------------------------------------------
	// Read address, LSU first
	// ------------------------------------------------------------------------
	assign io_master_arvalid = !rd_busy && (lsu_bus.arvalid || fetch_bus.arvalid);
	assign io_master_araddr  = lsu_bus.arvalid ? lsu_bus.araddr : fetch_bus.araddr;
	assign lsu_bus.arready   = !rd_busy && io_master_arready;
	assign fetch_bus.arready = !rd_busy && !lsu_bus.arvalid && io_master_arready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_busy <= 1'b0;
			rd_lsu  <= 1'b0;
		end else if (io_master_arvalid && io_master_arready) begin
			rd_busy <= 1'b1;
			rd_lsu  <= lsu_bus.arvalid;
		end else if (io_master_rvalid && io_master_rready) begin
			rd_busy <= 1'b0;
		end
	end

	assign io_master_rready  = rd_busy && (rd_lsu ? lsu_bus.rready : fetch_bus.rready);
	assign lsu_bus.rvalid    = rd_busy && rd_lsu && io_master_rvalid;
	assign fetch_bus.rvalid  = rd_busy && !rd_lsu && io_master_rvalid;
	assign lsu_bus.rdata     = io_master_rdata;
	assign fetch_bus.rdata   = io_master_rdata;
	assign lsu_bus.rresp     = io_master_rresp;
	assign fetch_bus.rresp   = io_master_rresp;

	// Writes come only from the LSU
	assign io_master_awvalid = lsu_bus.awvalid;
	assign io_master_awaddr  = lsu_bus.awaddr;
	assign io_master_wvalid  = lsu_bus.wvalid;
	assign io_master_wdata   = lsu_bus.wdata;
	assign io_master_wstrb   = lsu_bus.wstrb;
	assign io_master_bready  = lsu_bus.bready;
	assign lsu_bus.awready   = io_master_awready;
	assign lsu_bus.wready    = io_master_wready;
	assign lsu_bus.bvalid    = io_master_bvalid;
	assign lsu_bus.bresp     = io_master_bresp;
	assign fetch_bus.awready = 1'b0;
	assign fetch_bus.wready  = 1'b0;
	assign fetch_bus.bvalid  = 1'b0;
	assign fetch_bus.bresp   = '0;

	one_read: assert property (@(posedge clock) disable iff (!rst_n)
		rd_busy |-> !lsu_bus.arvalid && !fetch_bus.arvalid);
endmodule

// File: source/mem_if.sv
`timescale 1ns/10ps
`include "core_params.svh"

interface mem_if;
	logic [`XLEN-1:0]   araddr;
	logic               arvalid;
	logic               arready;
	logic [`XLEN-1:0]   rdata;
	logic [1:0]         rresp;
	logic               rvalid;
	logic               rready;
	logic [`XLEN-1:0]   awaddr;
	logic               awvalid;
	logic               awready;
	logic [`XLEN-1:0]   wdata;
	logic [`XLEN/8-1:0] wstrb;
	logic               wvalid;
	logic               wready;
	logic [1:0]         bresp;
	logic               bvalid;
	logic               bready;

	modport requester (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

	modport arbiter (
		input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);
endinterface

// File: source/rv32e_core.sv
`timescale 1ns/10ps
`include "core_params.svh"

module rv32e_core (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               io_master_awready,
	output logic               io_master_awvalid,
	output logic [`XLEN-1:0]   io_master_awaddr,
	input  logic               io_master_wready,
	output logic               io_master_wvalid,
	output logic [`XLEN-1:0]   io_master_wdata,
	output logic [`XLEN/8-1:0] io_master_wstrb,
	output logic               io_master_bready,
	input  logic               io_master_bvalid,
	input  logic [1:0]         io_master_bresp,
	input  logic               io_master_arready,
	output logic               io_master_arvalid,
	output logic [`XLEN-1:0]   io_master_araddr,
	output logic               io_master_rready,
	input  logic               io_master_rvalid,
	input  logic [1:0]         io_master_rresp,
	input  logic [`XLEN-1:0]   io_master_rdata
);
	import core_pkg::*;

	logic [`XLEN-1:0]          pc, next_pc;
	inst_word_t                inst;
	logic                      exec_start, wb_valid;
	logic [$clog2(`NREGS)-1:0] rs1_addr, rs2_addr, rd_addr;
	logic [`XLEN-1:0]          rs1_data, rs2_data, rd_wdata;
	logic                      rd_wen;
	logic                      mem_start, mem_write, lsu_done;
	logic [`XLEN-1:0]          mem_addr, mem_wdata, load_data;

	mem_if fetch_bus ();
	mem_if lsu_bus ();

	core_fetch my_fetch (
		.clock(clock), .rst_n(rst_n), .wb_valid(wb_valid), .next_pc(next_pc),
		.bus(fetch_bus), .pc(pc), .inst(inst), .exec_start(exec_start)
	);

	core_exec my_exec (
		.clock(clock), .rst_n(rst_n), .pc(pc), .inst(inst), .exec_start(exec_start),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .lsu_done(lsu_done), .load_data(load_data),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr), .rd_wdata(rd_wdata),
		.rd_wen(rd_wen), .next_pc(next_pc), .mem_start(mem_start), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_write(mem_write), .wb_valid(wb_valid)
	);

	core_regfile #(.NREGS(`NREGS)) my_reg (
		.clock(clock), .rst_n(rst_n), .raddr1(rs1_addr), .raddr2(rs2_addr), .waddr(rd_addr),
		.wdata(rd_wdata), .wen(rd_wen), .wb_valid(wb_valid), .rdata1(rs1_data), .rdata2(rs2_data)
	);

	core_lsu my_lsu (
		.clock(clock), .rst_n(rst_n), .mem_start(mem_start), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_write(mem_write), .bus(lsu_bus),
		.lsu_done(lsu_done), .load_data(load_data)
	);

	mem_arbiter my_arbiter (
		.fetch_bus(fetch_bus), .lsu_bus(lsu_bus), .clock(clock), .rst_n(rst_n),
		.io_master_awready(io_master_awready), .io_master_wready(io_master_wready),
		.io_master_bvalid(io_master_bvalid), .io_master_bresp(io_master_bresp),
		.io_master_arready(io_master_arready), .io_master_rvalid(io_master_rvalid),
		.io_master_rresp(io_master_rresp), .io_master_rdata(io_master_rdata),
		.io_master_awvalid(io_master_awvalid), .io_master_awaddr(io_master_awaddr),
		.io_master_wvalid(io_master_wvalid), .io_master_wdata(io_master_wdata),
		.io_master_wstrb(io_master_wstrb), .io_master_bready(io_master_bready),
		.io_master_arvalid(io_master_arvalid), .io_master_araddr(io_master_araddr),
		.io_master_rready(io_master_rready)
	);
endmodule

// File: verification/core_tb.sv
`timescale 1ns/10ps
`include "core_params.svh"

module core_tb;
	localparam int VEC_WORDS = 64;
	localparam int INFO_BASE = 32;                  // Program length, store count, then pairs

	logic        clock;
	logic        rst_n;
	logic        io_master_awready, io_master_awvalid, io_master_wready, io_master_wvalid;
	logic        io_master_bready, io_master_bvalid, io_master_arready, io_master_arvalid;
	logic        io_master_rready, io_master_rvalid;
	logic [31:0] io_master_awaddr, io_master_wdata, io_master_araddr, io_master_rdata;
	logic [3:0]  io_master_wstrb;
	logic [1:0]  io_master_bresp, io_master_rresp;

	logic [31:0] vec [0:VEC_WORDS-1];
	logic [31:0] mem [0:255];
	logic [31:0] lfsr;
	int          prog_words, store_count, stores_seen, errors, checks, cycles, limit;
	int          ar_dly, r_dly, aw_dly, w_dly, b_dly;
	logic        r_busy, r_fire_q, b_busy, b_fire_q, aw_done, w_done, first_seen, done;
	logic        ar_hold, aw_hold, w_hold;
	logic [31:0] r_addr, ar_addr_h, aw_addr_h, w_data_h, aw_addr_q, w_data_q;
	logic [3:0]  w_strb_q;

	rv32e_core i_dut (.*);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb)
			s = s ^ 32'ha300_0000;
		return s;
	endfunction

	// 0 to 3 cycles, one LFSR step per bit
	function automatic int next_delay();
		int d;
		d = 0;
		for (int i = 0; i < 2; i++) begin
			d = (d << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
		return d;
	endfunction

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// ------------------------------------------------------------------------
	// Memory slave, all outputs change on the falling edge
	// ------------------------------------------------------------------------
	always @(negedge clock) begin
		if (rst_n) begin
			if (ar_hold) begin
				checks++;
				assert (io_master_arvalid && io_master_araddr == ar_addr_h) else begin
					$display("Read address request dropped or changed before its transfer");
					errors++;
				end
			end
			if (aw_hold) begin
				checks++;
				assert (io_master_awvalid && io_master_awaddr == aw_addr_h) else begin
					$display("Write address request dropped or changed before its transfer");
					errors++;
				end
			end
			if (w_hold) begin
				checks++;
				assert (io_master_wvalid && io_master_wdata == w_data_h) else begin
					$display("Write data dropped or changed before its transfer");
					errors++;
				end
			end
			if (r_fire_q) begin                   // Read data went over last edge
				io_master_rvalid = 1'b0;
				r_fire_q = 1'b0;
			end
			if (r_busy && !io_master_rvalid) begin
				if (r_dly == 0) begin
					io_master_rvalid = 1'b1;
					io_master_rdata = mem[r_addr[9:2]];
				end else
					r_dly--;
			end
			if (io_master_rvalid && io_master_rready) begin
				r_fire_q = 1'b1;
				r_busy = 1'b0;
			end
			if (io_master_arvalid && !r_busy) begin
				io_master_arready = (ar_dly == 0);
				if (ar_dly != 0)
					ar_dly--;
			end else
				io_master_arready = 1'b0;
			ar_hold = io_master_arvalid && !io_master_arready;
			ar_addr_h = io_master_araddr;
			if (io_master_arvalid && io_master_arready) begin
				if (!first_seen) begin
					checks++;
					assert (io_master_araddr == `RESET_PC) else begin
						$display("[FAIL] io_master_araddr expected %h actual %h",
							`RESET_PC, io_master_araddr);
						errors++;
					end
					first_seen = 1'b1;
				end
				if (io_master_araddr == 32'(prog_words - 1) * 4)
					done = 1'b1;                  // Reached the final self loop
				r_busy = 1'b1;
				r_addr = io_master_araddr;
				r_dly = next_delay();
				ar_dly = next_delay();
			end
			if (b_fire_q) begin
				io_master_bvalid = 1'b0;
				b_fire_q = 1'b0;
			end
			if (b_busy && !io_master_bvalid) begin
				if (b_dly == 0)
					io_master_bvalid = 1'b1;
				else
					b_dly--;
			end
			if (io_master_bvalid && io_master_bready) begin
				b_fire_q = 1'b1;
				b_busy = 1'b0;
			end
			io_master_awready = io_master_awvalid && !aw_done && aw_dly == 0;
			if (io_master_awvalid && !aw_done && aw_dly != 0)
				aw_dly--;
			aw_hold = io_master_awvalid && !io_master_awready;
			aw_addr_h = io_master_awaddr;
			if (io_master_awvalid && io_master_awready) begin
				aw_done = 1'b1;
				aw_addr_q = io_master_awaddr;
				aw_dly = next_delay();
			end
			io_master_wready = io_master_wvalid && !w_done && w_dly == 0;
			if (io_master_wvalid && !w_done && w_dly != 0)
				w_dly--;
			w_hold = io_master_wvalid && !io_master_wready;
			w_data_h = io_master_wdata;
			if (io_master_wvalid && io_master_wready) begin
				w_done = 1'b1;
				w_data_q = io_master_wdata;
				w_strb_q = io_master_wstrb;
				w_dly = next_delay();
			end
			if (aw_done && w_done) begin          // Whole store seen, compare it
				checks = checks + 2;
				assert (stores_seen < store_count) else begin
					$display("Store to %h is not in the expected sequence", aw_addr_q);
					errors++;
				end
				if (stores_seen < store_count) begin
					checks = checks + 2;
					assert (aw_addr_q == vec[INFO_BASE + 2 + 2 * stores_seen]) else begin
						$display("[FAIL] io_master_awaddr expected %h actual %h",
							vec[INFO_BASE + 2 + 2 * stores_seen], aw_addr_q);
						errors++;
					end
					assert (w_data_q == vec[INFO_BASE + 3 + 2 * stores_seen]) else begin
						$display("[FAIL] io_master_wdata expected %h actual %h",
							vec[INFO_BASE + 3 + 2 * stores_seen], w_data_q);
						errors++;
					end
				end
				assert (w_strb_q == 4'hf) else begin
					$display("[FAIL] io_master_wstrb expected %h actual %h", 4'hf, w_strb_q);
					errors++;
				end
				mem[aw_addr_q[9:2]] = w_data_q;
				stores_seen++;
				aw_done = 1'b0;
				w_done = 1'b0;
				b_busy = 1'b1;
				b_dly = next_delay();
			end
		end
	end

	initial begin
		$readmemh("verification/core_vectors.hex", vec);
		prog_words = int'(vec[INFO_BASE]);
		store_count = int'(vec[INFO_BASE + 1]);
		limit = prog_words * 40 * 4;
		for (int i = 0; i < 256; i++)
			mem[i] = (i < prog_words) ? vec[i] : (32'hdead_0000 | 32'(i));
		lfsr = 32'he276;
		rst_n = 1'b0;
		{io_master_awready, io_master_wready, io_master_bvalid, io_master_arready} = '0;
		{io_master_rvalid, io_master_rdata, io_master_rresp, io_master_bresp} = '0;
		{r_busy, r_fire_q, b_busy, b_fire_q, aw_done, w_done, first_seen, done} = '0;
		{ar_hold, aw_hold, w_hold} = '0;
		{r_addr, ar_addr_h, aw_addr_h, w_data_h, aw_addr_q, w_data_q, w_strb_q} = '0;
		{stores_seen, errors, checks, cycles} = '0;
		{r_dly, b_dly} = '0;
		ar_dly = next_delay();
		aw_dly = next_delay();
		w_dly = next_delay();
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		while (!done && cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		if (!done) begin
			$display("Timeout after %0d cycles without reaching the final loop", cycles);
			errors++;
		end else if (stores_seen != store_count) begin
			$display("Only %0d of %0d expected stores were seen", stores_seen, store_count);
			errors++;
		end
		$display("Checks: %0d  Errors: %0d  Stores: %0d", checks, errors, stores_seen);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end
endmodule

// File: verification/core_vectors.hex
// Words 0x00..0x1f: program image, one instruction word per line at address 0
// Word 0x20: program words, 0x21: store count, then expected store address/data pairs
@0
20000093 // addi x1, x0, 0x200
00500113 // addi x2, x0, 5
ffd00193 // addi x3, x0, -3
00310233 // add  x4, x2, x3
403102b3 // sub  x5, x2, x3
12345337 // lui  x6, 0x12345
0040a023 // sw   x4, 0(x1)
0050a223 // sw   x5, 4(x1)
0060a423 // sw   x6, 8(x1)
0080a383 // lw   x7, 8(x1)
0070a623 // sw   x7, 12(x1)
00700013 // addi x0, x0, 7
0000a823 // sw   x0, 16(x1)
00310463 // beq  x2, x3, +8 not taken
00311463 // bne  x2, x3, +8 taken
0020aa23 // sw   x2, 20(x1) skipped
00210463 // beq  x2, x2, +8 taken
0030aa23 // sw   x3, 20(x1) skipped
0080046f // jal  x8, +8
0020aa23 // sw   x2, 20(x1) skipped
0080aa23 // sw   x8, 20(x1)
00211463 // bne  x2, x2, +8 not taken
0030ac23 // sw   x3, 24(x1)
0000006f // jal  x0, 0
@20
00000018 // program words
00000007 // expected stores
00000200 00000002
00000204 00000008
00000208 12345000
0000020c 12345000
00000210 00000000
00000214 0000004c
00000218 fffffffd
